// File: cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// Datapath and address width
`define CPU_XLEN 32

// Architectural register file
`define CPU_NREG 32
`define CPU_REG_AW 5

// Boot vector of the fetch unit
`define CPU_RESET_PC 32'hbfc00000

// Word index width of the one-cycle SRAM model
`define CPU_MEM_AW 8

`endif

// File: cpu_pkg.sv
`include "cpu_defs.svh"

package cpu_pkg;

	// Primary opcode field, inst[31:26]
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00,  // Register form, see funct
		OP_J       = 6'h02,
		OP_JAL     = 6'h03,
		OP_BEQ     = 6'h04,
		OP_BNE     = 6'h05,
		OP_ADDIU   = 6'h09,
		OP_SLTI    = 6'h0a,
		OP_ANDI    = 6'h0c,
		OP_ORI     = 6'h0d,
		OP_XORI    = 6'h0e,
		OP_LUI     = 6'h0f,
		OP_LW      = 6'h23,
		OP_SW      = 6'h2b
	} opcode_e;

	// Function field of the special group, inst[5:0]
	typedef enum logic [5:0] {
		FN_SLL  = 6'h00,
		FN_SRL  = 6'h02,
		FN_JR   = 6'h08,
		FN_ADDU = 6'h21,
		FN_SUBU = 6'h23,
		FN_AND  = 6'h24,
		FN_OR   = 6'h25,
		FN_XOR  = 6'h26,
		FN_NOR  = 6'h27,
		FN_SLT  = 6'h2a,
		FN_SLTU = 6'h2b
	} funct_e;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_NOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,   // Shifts take the amount in operand a
		ALU_SRL,
		ALU_LUI
	} alu_op_e;

	typedef enum logic [1:0] {
		WB_ALU,
		WB_MEM,
		WB_LINK    // PC+8 of a JAL
	} wb_sel_e;

	// Pending register write of a stage, seen by decode
	typedef struct packed {
		logic                   valid;  // Data already known
		logic                   we;     // Item will write dest
		logic [`CPU_REG_AW-1:0] dest;
		logic [`CPU_XLEN-1:0]   data;
	} fwd_t;

	typedef struct packed {
		logic                 valid;
		logic [`CPU_XLEN-1:0] pc;
	} if_id_t;

	typedef struct packed {
		logic                   valid;
		logic [`CPU_XLEN-1:0]   pc;
		alu_op_e                alu_op;
		logic [`CPU_XLEN-1:0]   src_a;
		logic [`CPU_XLEN-1:0]   src_b;
		logic [`CPU_XLEN-1:0]   st_data;  // Forwarded rt for SW
		logic [`CPU_REG_AW-1:0] dest;
		logic                   we;
		logic                   mem_read;
		logic                   mem_write;
		wb_sel_e                wb_sel;
	} id_ex_t;

	typedef struct packed {
		logic                   valid;
		logic [`CPU_XLEN-1:0]   pc;
		logic [`CPU_XLEN-1:0]   result;   // ALU value, address or link
		logic [`CPU_XLEN-1:0]   st_data;
		logic [`CPU_REG_AW-1:0] dest;
		logic                   we;
		logic                   mem_read;
		logic                   mem_write;
		wb_sel_e                wb_sel;
	} ex_mem_t;

	typedef struct packed {
		logic                   valid;
		logic [`CPU_XLEN-1:0]   pc;
		logic [`CPU_XLEN-1:0]   result;
		logic [`CPU_REG_AW-1:0] dest;
		logic                   we;
		logic                   is_load;  // Take SRAM read data
	} mem_wb_t;

	typedef struct packed {
		logic                 taken;
		logic [`CPU_XLEN-1:0] target;
	} redirect_t;

endpackage

// File: cpu_regfile.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_regfile (
	input  logic                   clk,
	input  logic                   resetn,
	input  logic [`CPU_REG_AW-1:0] i_raddr1,
	input  logic [`CPU_REG_AW-1:0] i_raddr2,
	output logic [`CPU_XLEN-1:0]   o_rdata1,
	output logic [`CPU_XLEN-1:0]   o_rdata2,
	input  logic                   i_we,
	input  logic [`CPU_REG_AW-1:0] i_waddr,
	input  logic [`CPU_XLEN-1:0]   i_wdata
);

	logic [`CPU_XLEN-1:0] regs [`CPU_NREG];

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			for (int k = 0; k < `CPU_NREG; k++)
				regs[k] <= '0;
		end
		else if (i_we && i_waddr != '0)  // r0 stays zero
			regs[i_waddr] <= i_wdata;
	end

	// Same-cycle write is covered by the write-back forward in decode
	assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
	assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

// File: cpu_fetch.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_fetch (
	input  logic                 clk,
	input  logic                 resetn,
	input  logic                 i_id_allow_in,
	input  cpu_pkg::redirect_t   i_redirect,
	output logic                 o_inst_en,
	output logic [`CPU_XLEN-1:0] o_inst_addr,
	output cpu_pkg::if_id_t      o_if_id
);

	logic [`CPU_XLEN-1:0] pc;       // Address now sent to the SRAM
	logic [`CPU_XLEN-1:0] pc_next;

	// Branch in decode picks the word after the delay slot
	assign pc_next = i_redirect.taken ? i_redirect.target : pc + 32'd4;

	assign o_inst_en   = i_id_allow_in;  // Read only when decode can take the word
	assign o_inst_addr = pc;

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			pc <= `CPU_RESET_PC;
		else if (i_id_allow_in)
			pc <= pc_next;
	end

	// Word arrives one cycle later, tagged with its PC
	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			o_if_id <= '0;
		else if (i_id_allow_in)
			o_if_id <= '{valid: 1'b1, pc: pc};
	end

endmodule

// File: cpu_decode.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_decode (
	input  logic                   clk,
	input  logic                   resetn,
	input  cpu_pkg::if_id_t        i_if_id,
	input  logic [`CPU_XLEN-1:0]   i_inst_rdata,
	output logic [`CPU_REG_AW-1:0] o_raddr1,
	output logic [`CPU_REG_AW-1:0] o_raddr2,
	input  logic [`CPU_XLEN-1:0]   i_rdata1,
	input  logic [`CPU_XLEN-1:0]   i_rdata2,
	input  cpu_pkg::fwd_t          i_fwd_ex,
	input  cpu_pkg::fwd_t          i_fwd_mem,
	input  cpu_pkg::fwd_t          i_fwd_wb,
	input  logic                   i_ex_allow_in,
	output logic                   o_allow_in,
	output cpu_pkg::redirect_t     o_redirect,
	output cpu_pkg::id_ex_t        o_id_ex
);
	import cpu_pkg::*;

	logic [`CPU_XLEN-1:0]   inst;
	logic [`CPU_XLEN-1:0]   hold_inst;  // Word kept over a stall
	logic                   hold_vld;
	opcode_e                op;
	funct_e                 fn;
	logic [`CPU_REG_AW-1:0] rs;
	logic [`CPU_REG_AW-1:0] rt;
	logic [`CPU_REG_AW-1:0] rd;
	logic [`CPU_REG_AW-1:0] sa;
	logic [15:0]            imm;
	logic [`CPU_XLEN-1:0]   sext;
	logic [`CPU_XLEN-1:0]   zext;
	logic [`CPU_XLEN-1:0]   pc4;
	logic [`CPU_XLEN-1:0]   src_a;
	logic [`CPU_XLEN-1:0]   src_b;
	fwd_t                   rs_f;
	fwd_t                   rt_f;
	alu_op_e                alu_op;
	wb_sel_e                wb_sel;
	logic [`CPU_REG_AW-1:0] dest;
	logic                   we;
	logic                   mem_rd;
	logic                   mem_wr;
	logic                   use_rs;
	logic                   use_rt;
	logic                   use_sa;
	logic                   b_imm;
	logic                   b_zext;
	logic                   is_beq;
	logic                   is_bne;
	logic                   is_j;
	logic                   is_jr;
	logic                   br_taken;
	logic                   stall;
	logic                   ready_go;

	// Youngest matching write wins, register 0 never forwards
	function automatic fwd_t pick(input logic [`CPU_REG_AW-1:0] r,
		input logic [`CPU_XLEN-1:0] rf_data, input fwd_t f_ex, input fwd_t f_mem,
		input fwd_t f_wb);
		fwd_t res;
		fwd_t src [3];
		res = '{valid: 1'b1, we: 1'b0, dest: r, data: rf_data};
		src = '{f_wb, f_mem, f_ex};  // Oldest first
		for (int k = 0; k < 3; k++)
			if (src[k].we && src[k].dest == r && r != '0)
				res = src[k];
		return res;
	endfunction

	assign inst = hold_vld ? hold_inst : i_inst_rdata;
	assign op   = opcode_e'(inst[31:26]);
	assign fn   = funct_e'(inst[5:0]);
	assign rs   = inst[25:21];
	assign rt   = inst[20:16];
	assign rd   = inst[15:11];
	assign sa   = inst[10:6];
	assign imm  = inst[15:0];
	assign sext = {{16{imm[15]}}, imm};
	assign zext = {16'b0, imm};
	assign pc4  = i_if_id.pc + 32'd4;

	assign o_raddr1 = rs;
	assign o_raddr2 = rt;

	assign rs_f = pick(rs, i_rdata1, i_fwd_ex, i_fwd_mem, i_fwd_wb);
	assign rt_f = pick(rt, i_rdata2, i_fwd_ex, i_fwd_mem, i_fwd_wb);

	always_comb
	begin
		alu_op = ALU_ADD;
		wb_sel = WB_ALU;
		dest   = rt;    // I-type writes rt
		we     = 1'b0;
		mem_rd = 1'b0;
		mem_wr = 1'b0;
		use_rs = 1'b1;
		use_rt = 1'b0;
		use_sa = 1'b0;
		b_imm  = 1'b1;
		b_zext = 1'b0;
		is_beq = 1'b0;
		is_bne = 1'b0;
		is_j   = 1'b0;
		is_jr  = 1'b0;
		case (op)
			OP_SPECIAL:
			begin
				dest   = rd;
				we     = 1'b1;
				use_rt = 1'b1;
				b_imm  = 1'b0;
				case (fn)
					FN_ADDU: alu_op = ALU_ADD;
					FN_SUBU: alu_op = ALU_SUB;
					FN_AND:  alu_op = ALU_AND;
					FN_OR:   alu_op = ALU_OR;
					FN_XOR:  alu_op = ALU_XOR;
					FN_NOR:  alu_op = ALU_NOR;
					FN_SLT:  alu_op = ALU_SLT;
					FN_SLTU: alu_op = ALU_SLTU;
					FN_SLL:
					begin
						alu_op = ALU_SLL;
						use_sa = 1'b1;
					end
					FN_SRL:
					begin
						alu_op = ALU_SRL;
						use_sa = 1'b1;
					end
					FN_JR:
					begin
						we    = 1'b0;
						is_jr = 1'b1;
					end
					default: we = 1'b0;  // Unsupported, runs as a bubble
				endcase
			end
			OP_ADDIU: we = 1'b1;
			OP_SLTI:
			begin
				alu_op = ALU_SLT;
				we     = 1'b1;
			end
			OP_ANDI:
			begin
				alu_op = ALU_AND;
				b_zext = 1'b1;
				we     = 1'b1;
			end
			OP_ORI:
			begin
				alu_op = ALU_OR;
				b_zext = 1'b1;
				we     = 1'b1;
			end
			OP_XORI:
			begin
				alu_op = ALU_XOR;
				b_zext = 1'b1;
				we     = 1'b1;
			end
			OP_LUI:
			begin
				alu_op = ALU_LUI;
				we     = 1'b1;
			end
			OP_LW:
			begin
				wb_sel = WB_MEM;
				mem_rd = 1'b1;
				we     = 1'b1;
			end
			OP_SW:
			begin
				mem_wr = 1'b1;
				use_rt = 1'b1;  // Store data
			end
			OP_BEQ, OP_BNE:
			begin
				use_rt = 1'b1;
				is_beq = (op == OP_BEQ);
				is_bne = (op == OP_BNE);
			end
			OP_J, OP_JAL:
			begin
				use_rs = 1'b0;  // rs bits belong to the target
				is_j   = 1'b1;
				if (op == OP_JAL)
				begin
					dest   = 5'd31;
					wb_sel = WB_LINK;
					we     = 1'b1;
				end
			end
			default: use_rs = 1'b0;
		endcase
	end

	assign src_a = use_sa ? {{(`CPU_XLEN-5){1'b0}}, sa} : rs_f.data;
	assign src_b = !b_imm ? rt_f.data : (b_zext ? zext : sext);

	// Load still in execute or memory has no data yet
	assign stall = (use_rs & rs_f.we & ~rs_f.valid) | (use_rt & rt_f.we & ~rt_f.valid);

	assign ready_go   = i_if_id.valid & ~stall & i_ex_allow_in;
	assign o_allow_in = ~i_if_id.valid | ready_go;

	assign br_taken = (is_beq & (rs_f.data == rt_f.data)) | (is_bne & (rs_f.data != rt_f.data));

	assign o_redirect.taken  = ready_go & (br_taken | is_j | is_jr);
	assign o_redirect.target = is_jr ? rs_f.data :
		is_j ? {pc4[31:28], inst[25:0], 2'b00} :  // 256 MB region of pc+4
		pc4 + {sext[29:0], 2'b00};

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			hold_vld <= 1'b0;
		else
			hold_vld <= i_if_id.valid & ~ready_go;
	end

	// Refreshed until the first stalled cycle, then frozen
	always_ff @(posedge clk)
	begin
		if (!hold_vld)
			hold_inst <= i_inst_rdata;
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			o_id_ex <= '0;
		else if (ready_go)
			o_id_ex <= '{
				valid:     1'b1,
				pc:        i_if_id.pc,
				alu_op:    alu_op,
				src_a:     src_a,
				src_b:     src_b,
				st_data:   rt_f.data,
				dest:      dest,
				we:        we & (dest != '0),  // r0 writes dropped here
				mem_read:  mem_rd,
				mem_write: mem_wr,
				wb_sel:    wb_sel
			};
		else if (i_ex_allow_in)
			o_id_ex.valid <= 1'b0;  // Item left, bubble follows
	end

endmodule

// File: cpu_execute.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_execute (
	input  logic             clk,
	input  logic             resetn,
	input  cpu_pkg::id_ex_t  i_id_ex,
	input  logic             i_mem_allow_in,
	output logic             o_allow_in,
	output cpu_pkg::fwd_t    o_fwd,
	output cpu_pkg::ex_mem_t o_ex_mem
);
	import cpu_pkg::*;

	logic [`CPU_XLEN-1:0] a;
	logic [`CPU_XLEN-1:0] b;
	logic [`CPU_XLEN-1:0] alu_res;
	logic [`CPU_XLEN-1:0] result;
	logic                 ready_go;

	assign a = i_id_ex.src_a;
	assign b = i_id_ex.src_b;

	always_comb
	begin
		case (i_id_ex.alu_op)
			ALU_ADD:  alu_res = a + b;
			ALU_SUB:  alu_res = a - b;
			ALU_AND:  alu_res = a & b;
			ALU_OR:   alu_res = a | b;
			ALU_XOR:  alu_res = a ^ b;
			ALU_NOR:  alu_res = ~(a | b);
			ALU_SLT:  alu_res = {31'b0, $signed(a) < $signed(b)};
			ALU_SLTU: alu_res = {31'b0, a < b};
			ALU_SLL:  alu_res = b << a[4:0];
			ALU_SRL:  alu_res = b >> a[4:0];
			ALU_LUI:  alu_res = {b[15:0], 16'b0};
			default:  alu_res = '0;
		endcase
	end

	assign result = (i_id_ex.wb_sel == WB_LINK) ? i_id_ex.pc + 32'd8 : alu_res;

	// Load result unknown until write-back, decode stalls on it
	assign o_fwd = '{
		valid: i_id_ex.wb_sel != WB_MEM,
		we:    i_id_ex.valid & i_id_ex.we,
		dest:  i_id_ex.dest,
		data:  result
	};

	assign ready_go   = i_id_ex.valid & i_mem_allow_in;
	assign o_allow_in = ~i_id_ex.valid | ready_go;

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			o_ex_mem <= '0;
		else if (ready_go)
			o_ex_mem <= '{
				valid:     1'b1,
				pc:        i_id_ex.pc,
				result:    result,
				st_data:   i_id_ex.st_data,
				dest:      i_id_ex.dest,
				we:        i_id_ex.we,
				mem_read:  i_id_ex.mem_read,
				mem_write: i_id_ex.mem_write,
				wb_sel:    i_id_ex.wb_sel
			};
		else if (i_mem_allow_in)
			o_ex_mem.valid <= 1'b0;
	end

endmodule

// File: cpu_mem_wb.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_mem_wb (
	input  logic                   clk,
	input  logic                   resetn,
	input  cpu_pkg::ex_mem_t       i_ex_mem,
	output logic                   o_allow_in,
	output cpu_pkg::fwd_t          o_fwd_mem,
	output cpu_pkg::fwd_t          o_fwd_wb,
	output logic                   o_data_en,
	output logic                   o_data_we,
	output logic [`CPU_XLEN-1:0]   o_data_addr,
	output logic [`CPU_XLEN-1:0]   o_data_wdata,
	input  logic [`CPU_XLEN-1:0]   i_data_rdata,
	output logic                   o_rf_we,
	output logic [`CPU_REG_AW-1:0] o_rf_waddr,
	output logic [`CPU_XLEN-1:0]   o_rf_wdata,
	output logic [`CPU_XLEN-1:0]   o_wb_pc,
	output logic                   o_wb_rf_we,
	output logic [`CPU_REG_AW-1:0] o_wb_rf_wnum,
	output logic [`CPU_XLEN-1:0]   o_wb_rf_wdata
);
	import cpu_pkg::*;

	mem_wb_t              wb_q;
	logic                 is_load;
	logic [`CPU_XLEN-1:0] wb_data;

	assign o_allow_in = 1'b1;  // Write-back never holds, memory always drains
	assign is_load    = (i_ex_mem.wb_sel == WB_MEM);

	// Full-word access only
	assign o_data_en    = i_ex_mem.valid & (i_ex_mem.mem_read | i_ex_mem.mem_write);
	assign o_data_we    = i_ex_mem.valid & i_ex_mem.mem_write;
	assign o_data_addr  = i_ex_mem.result;
	assign o_data_wdata = i_ex_mem.st_data;

	assign o_fwd_mem = '{
		valid: ~is_load,  // Read data not back yet
		we:    i_ex_mem.valid & i_ex_mem.we,
		dest:  i_ex_mem.dest,
		data:  i_ex_mem.result
	};

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			wb_q <= '0;
		else if (i_ex_mem.valid)
			wb_q <= '{
				valid:   1'b1,
				pc:      i_ex_mem.pc,
				result:  i_ex_mem.result,
				dest:    i_ex_mem.dest,
				we:      i_ex_mem.we,
				is_load: is_load
			};
		else
			wb_q.valid <= 1'b0;  // Bubble from memory
	end

	// SRAM data lines up with the item one cycle after the request
	assign wb_data = wb_q.is_load ? i_data_rdata : wb_q.result;

	assign o_rf_we    = wb_q.valid & wb_q.we;
	assign o_rf_waddr = wb_q.dest;
	assign o_rf_wdata = wb_data;

	assign o_fwd_wb = '{valid: 1'b1, we: o_rf_we, dest: wb_q.dest, data: wb_data};

	// Trace mirrors the register file write
	assign o_wb_pc       = wb_q.pc;
	assign o_wb_rf_we    = o_rf_we;
	assign o_wb_rf_wnum  = wb_q.dest;
	assign o_wb_rf_wdata = wb_data;

endmodule

// File: cpu_top.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module cpu_top (
	input  logic                   clk,
	input  logic                   resetn,
	output logic                   o_inst_en,
	output logic [`CPU_XLEN-1:0]   o_inst_addr,
	input  logic [`CPU_XLEN-1:0]   i_inst_rdata,
	output logic                   o_data_en,
	output logic                   o_data_we,
	output logic [`CPU_XLEN-1:0]   o_data_addr,
	output logic [`CPU_XLEN-1:0]   o_data_wdata,
	input  logic [`CPU_XLEN-1:0]   i_data_rdata,
	output logic [`CPU_XLEN-1:0]   o_wb_pc,
	output logic                   o_wb_rf_we,
	output logic [`CPU_REG_AW-1:0] o_wb_rf_wnum,
	output logic [`CPU_XLEN-1:0]   o_wb_rf_wdata
);
	import cpu_pkg::*;

	if_id_t                 if_id;
	id_ex_t                 id_ex;
	ex_mem_t                ex_mem;
	redirect_t              redirect;
	fwd_t                   fwd_ex;
	fwd_t                   fwd_mem;
	fwd_t                   fwd_wb;
	logic                   id_allow_in;
	logic                   ex_allow_in;
	logic                   mem_allow_in;
	logic [`CPU_REG_AW-1:0] raddr1;
	logic [`CPU_REG_AW-1:0] raddr2;
	logic [`CPU_XLEN-1:0]   rdata1;
	logic [`CPU_XLEN-1:0]   rdata2;
	logic                   rf_we;
	logic [`CPU_REG_AW-1:0] rf_waddr;
	logic [`CPU_XLEN-1:0]   rf_wdata;

	cpu_fetch u_fetch (
		.clk           (clk),
		.resetn        (resetn),
		.i_id_allow_in (id_allow_in),
		.i_redirect    (redirect),
		.o_inst_en     (o_inst_en),
		.o_inst_addr   (o_inst_addr),
		.o_if_id       (if_id)
	);

	cpu_decode u_decode (
		.clk           (clk),
		.resetn        (resetn),
		.i_if_id       (if_id),
		.i_inst_rdata  (i_inst_rdata),
		.o_raddr1      (raddr1),
		.o_raddr2      (raddr2),
		.i_rdata1      (rdata1),
		.i_rdata2      (rdata2),
		.i_fwd_ex      (fwd_ex),
		.i_fwd_mem     (fwd_mem),
		.i_fwd_wb      (fwd_wb),
		.i_ex_allow_in (ex_allow_in),
		.o_allow_in    (id_allow_in),
		.o_redirect    (redirect),
		.o_id_ex       (id_ex)
	);

	cpu_regfile u_regfile (
		.clk      (clk),
		.resetn   (resetn),
		.i_raddr1 (raddr1),
		.i_raddr2 (raddr2),
		.o_rdata1 (rdata1),
		.o_rdata2 (rdata2),
		.i_we     (rf_we),
		.i_waddr  (rf_waddr),
		.i_wdata  (rf_wdata)
	);

	cpu_execute u_execute (
		.clk            (clk),
		.resetn         (resetn),
		.i_id_ex        (id_ex),
		.i_mem_allow_in (mem_allow_in),
		.o_allow_in     (ex_allow_in),
		.o_fwd          (fwd_ex),
		.o_ex_mem       (ex_mem)
	);

	cpu_mem_wb u_mem_wb (
		.clk           (clk),
		.resetn        (resetn),
		.i_ex_mem      (ex_mem),
		.o_allow_in    (mem_allow_in),
		.o_fwd_mem     (fwd_mem),
		.o_fwd_wb      (fwd_wb),
		.o_data_en     (o_data_en),
		.o_data_we     (o_data_we),
		.o_data_addr   (o_data_addr),
		.o_data_wdata  (o_data_wdata),
		.i_data_rdata  (i_data_rdata),
		.o_rf_we       (rf_we),
		.o_rf_waddr    (rf_waddr),
		.o_rf_wdata    (rf_wdata),
		.o_wb_pc       (o_wb_pc),
		.o_wb_rf_we    (o_wb_rf_we),
		.o_wb_rf_wnum  (o_wb_rf_wnum),
		.o_wb_rf_wdata (o_wb_rf_wdata)
	);

endmodule

// File: tb_sram.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module tb_sram (
	input  logic                 clk,
	input  logic                 i_en,
	input  logic                 i_we,
	input  logic [`CPU_XLEN-1:0] i_addr,
	input  logic [`CPU_XLEN-1:0] i_wdata,
	output logic [`CPU_XLEN-1:0] o_rdata
);

	logic [`CPU_XLEN-1:0]   mem [1 << `CPU_MEM_AW];  // Loaded by the testbench top
	logic [`CPU_MEM_AW-1:0] idx;

	assign idx = i_addr[`CPU_MEM_AW+1:2];  // Word index, upper bits wrap

	initial
		o_rdata = '0;

	// Read returns the old word on a write
	always @(posedge clk)
	begin
		if (i_en)
		begin
			if (i_we)
				mem[idx] <= i_wdata;
			o_rdata <= mem[idx];
		end
	end

endmodule

// File: tb_cpu.sv
`timescale 1ns/1ps
`include "cpu_defs.svh"

module tb_cpu;

	logic                   clk;
	logic                   resetn;
	logic                   inst_en;
	logic [`CPU_XLEN-1:0]   inst_addr;
	logic [`CPU_XLEN-1:0]   inst_rdata;
	logic                   data_en;
	logic                   data_we;
	logic [`CPU_XLEN-1:0]   data_addr;
	logic [`CPU_XLEN-1:0]   data_wdata;
	logic [`CPU_XLEN-1:0]   data_rdata;
	logic [`CPU_XLEN-1:0]   wb_pc;
	logic                   wb_we;
	logic [`CPU_REG_AW-1:0] wb_num;
	logic [`CPU_XLEN-1:0]   wb_data;

	logic [`CPU_XLEN-1:0]   exp_pc [$];    // Expected trace, program order
	logic [`CPU_REG_AW-1:0] exp_num [$];
	logic [`CPU_XLEN-1:0]   exp_data [$];
	int                     exp_idx;       // Next entry to match
	int                     mismatch_errs;
	int                     extra_errs;    // Trace writes past the last entry
	int                     missing_errs;
	int                     bus_errs;      // Bad data SRAM requests
	int                     file_errs;
	int                     cycles;
	int                     cycle_limit;

	cpu_top u_cpu_top (
		.clk           (clk),
		.resetn        (resetn),
		.o_inst_en     (inst_en),
		.o_inst_addr   (inst_addr),
		.i_inst_rdata  (inst_rdata),
		.o_data_en     (data_en),
		.o_data_we     (data_we),
		.o_data_addr   (data_addr),
		.o_data_wdata  (data_wdata),
		.i_data_rdata  (data_rdata),
		.o_wb_pc       (wb_pc),
		.o_wb_rf_we    (wb_we),
		.o_wb_rf_wnum  (wb_num),
		.o_wb_rf_wdata (wb_data)
	);

	// Program memory that is never written
	tb_sram u_imem (
		.clk     (clk),
		.i_en    (inst_en),
		.i_we    (1'b0),
		.i_addr  (inst_addr),
		.i_wdata ('0),
		.o_rdata (inst_rdata)
	);

	tb_sram u_dmem (
		.clk     (clk),
		.i_en    (data_en),
		.i_we    (data_we),
		.i_addr  (data_addr),
		.i_wdata (data_wdata),
		.o_rdata (data_rdata)
	);

	always #5 clk = ~clk;  // 10 ns period

	// Fills both memories and the expected trace from the case file
	task automatic load_cases();
		int                   fd;
		int                   r;
		logic [63:0]          tag;
		logic [8*128-1:0]     line;
		logic [`CPU_XLEN-1:0] f_a;
		logic [`CPU_XLEN-1:0] f_b;
		logic [`CPU_XLEN-1:0] f_c;
		for (int k = 0; k < (1 << `CPU_MEM_AW); k++)
		begin
			u_imem.mem[k] = '0;  // Zero word is a NOP
			u_dmem.mem[k] = '0;
		end
		fd = $fopen("cpu_cases.txt", "r");
		if (fd == 0)
		begin
			file_errs++;
			$display("cannot open cpu_cases.txt");
			return;
		end
		while ($fscanf(fd, "%s", tag) == 1)
		begin
			if (tag == "#")
				r = $fgets(line, fd);  // Drop the rest of a comment line
			else if (tag == "I")
			begin
				r = $fscanf(fd, "%h %h", f_a, f_b);
				u_imem.mem[f_a[`CPU_MEM_AW+1:2]] = f_b;
			end
			else if (tag == "D")
			begin
				r = $fscanf(fd, "%h %h", f_a, f_b);
				u_dmem.mem[f_a[`CPU_MEM_AW+1:2]] = f_b;
			end
			else if (tag == "E")
			begin
				r = $fscanf(fd, "%h %h %h", f_a, f_b, f_c);
				exp_pc.push_back(f_a);
				exp_num.push_back(f_b[`CPU_REG_AW-1:0]);
				exp_data.push_back(f_c);
			end
			else
			begin
				file_errs++;
				$display("unknown line tag in cpu_cases.txt");
				r = $fgets(line, fd);
			end
		end
		$fclose(fd);
		if (exp_pc.size() == 0)
		begin
			file_errs++;
			$display("cpu_cases.txt holds no expected trace entries");
		end
	endtask

	// Compares one DUT output with its expected value
	task automatic compare_output(input string name, input logic [`CPU_XLEN-1:0] got,
		input logic [`CPU_XLEN-1:0] exp_val);
		assert (got === exp_val)
		else
		begin
			mismatch_errs++;
			$display("MISMATCH %s expected %h got %h", name, exp_val, got);
		end
	endtask

	// Cleared pipeline during reset, full-word data requests after it
	always @(negedge clk)
	begin
		if (!resetn)
		begin
			compare_output("o_inst_en", inst_en, 1);
			compare_output("o_inst_addr", inst_addr, `CPU_RESET_PC);
			compare_output("o_data_en", data_en, 0);
			compare_output("o_data_we", data_we, 0);
			compare_output("o_wb_rf_we", wb_we, 0);
		end
		else
		begin
			assert (!data_we || data_en)
			else
			begin
				bus_errs++;
				$display("data SRAM write strobe raised without its enable");
			end
			assert (!data_en || data_addr[1:0] == 2'b00)
			else
			begin
				bus_errs++;
				$display("data SRAM access at address %h is not word aligned", data_addr);
			end
		end
	end

	// Trace is stable away from the rising edge
	always @(negedge clk)
	begin
		if (resetn && wb_we)
		begin
			assert (exp_idx < exp_pc.size())
			else
			begin
				extra_errs++;
				$display("trace write at pc %h to r%0d with no expected entry left",
					wb_pc, wb_num);
			end
			if (exp_idx < exp_pc.size())
			begin
				assert (wb_pc == exp_pc[exp_idx])
				else
				begin
					mismatch_errs++;
					$display("MISMATCH o_wb_pc expected %h got %h",
						exp_pc[exp_idx], wb_pc);
				end
				assert (wb_num == exp_num[exp_idx])
				else
				begin
					mismatch_errs++;
					$display("MISMATCH o_wb_rf_wnum expected %h got %h",
						exp_num[exp_idx], wb_num);
				end
				assert (wb_data == exp_data[exp_idx])
				else
				begin
					mismatch_errs++;
					$display("MISMATCH o_wb_rf_wdata expected %h got %h",
						exp_data[exp_idx], wb_data);
				end
				exp_idx++;
			end
		end
	end

	initial
	begin
		clk           = 1'b0;
		resetn        = 1'b0;
		exp_idx       = 0;
		mismatch_errs = 0;
		extra_errs    = 0;
		missing_errs  = 0;
		bus_errs      = 0;
		file_errs     = 0;
		cycles        = 0;
		load_cases();
		cycle_limit = 20 * exp_pc.size() + 100;
		repeat (8) @(posedge clk);
		resetn <= 1'b1;
		while (exp_idx < exp_pc.size() && cycles < cycle_limit)
		begin
			@(posedge clk);
			cycles++;
		end
		assert (exp_idx >= exp_pc.size())
		else
		begin
			missing_errs = exp_pc.size() - exp_idx;
			$display("cycle limit %0d reached with %0d expected trace entries missing",
				cycle_limit, missing_errs);
		end
		if (missing_errs == 0)
			repeat (20) @(posedge clk);  // Window for stray trace writes
		$display("errors: %0d mismatch, %0d unexpected, %0d missing, %0d bus, %0d case file",
			mismatch_errs, extra_errs, missing_errs, bus_errs, file_errs);
		if (mismatch_errs + extra_errs + missing_errs + bus_errs + file_errs == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

// File: cpu_cases.txt
# I <byte address> <instruction word>
# D <byte address> <data word>, E <pc> <register> <value> in trace order, all hex
I bfc00000 24010005
I bfc00004 3c021234
I bfc00008 34425678
I bfc0000c 304300ff
I bfc00010 3824ffff
I bfc00014 28250006
I bfc00018 00233021
I bfc0001c 00233823
I bfc00020 00474024
I bfc00024 00234825
I bfc00028 00495026
I bfc0002c 00015827
I bfc00030 00e1602a
I bfc00034 00e1682b
I bfc00038 00017100
I bfc0003c 00027a02
# Store, load back, load-use pairs
I bfc00040 24100040
I bfc00044 ae020000
I bfc00048 8e110000
I bfc0004c 02219021
I bfc00050 8e130004
I bfc00054 24140001
I bfc00058 0274a821
# Write to r0, then read it
I bfc0005c 24001234
I bfc00060 0001b021
# Branches, delay slots and skipped words
I bfc00064 10290002
I bfc00068 24170011
I bfc0006c 24180022
I bfc00070 10c90002
I bfc00074 24190033
I bfc00078 24190044
I bfc0007c 14260002
I bfc00080 241a0055
I bfc00084 241a0066
I bfc00088 14c90001
I bfc0008c 241b0077
I bfc00090 0ff00028
I bfc00094 241c0088
I bfc00098 0bf0002c
I bfc0009c 241d00aa
I bfc000a0 03e00008
I bfc000a4 241e00bb
I bfc000a8 241e00cc
I bfc000b0 03e01821
D 00000044 cafef00d
E bfc00000 01 00000005
E bfc00004 02 12340000
E bfc00008 02 12345678
E bfc0000c 03 00000078
E bfc00010 04 0000fffa
E bfc00014 05 00000001
E bfc00018 06 0000007d
E bfc0001c 07 ffffff8d
E bfc00020 08 12345608
E bfc00024 09 0000007d
E bfc00028 0a 12345605
E bfc0002c 0b fffffffa
E bfc00030 0c 00000001
E bfc00034 0d 00000000
E bfc00038 0e 00000050
E bfc0003c 0f 00123456
E bfc00040 10 00000040
E bfc00048 11 12345678
E bfc0004c 12 1234567d
E bfc00050 13 cafef00d
E bfc00054 14 00000001
E bfc00058 15 cafef00e
E bfc00060 16 00000005
E bfc00068 17 00000011
E bfc0006c 18 00000022
E bfc00074 19 00000033
E bfc00080 1a 00000055
E bfc0008c 1b 00000077
E bfc00090 1f bfc00098
E bfc00094 1c 00000088
E bfc000a4 1e 000000bb
E bfc0009c 1d 000000aa
E bfc000b0 03 bfc00098

// File: files.f
+incdir+.
cpu_pkg.sv
cpu_regfile.sv
cpu_fetch.sv
cpu_decode.sv
cpu_execute.sv
cpu_mem_wb.sv
cpu_top.sv
tb_sram.sv
tb_cpu.sv

// File: Bender.yml
package:
  name: cpu

export_include_dirs:
  - .

sources:
  - cpu_pkg.sv
  - cpu_regfile.sv
  - cpu_fetch.sv
  - cpu_decode.sv
  - cpu_execute.sv
  - cpu_mem_wb.sv
  - cpu_top.sv
  - target: test
    files:
      - tb_sram.sv
      - tb_cpu.sv
